/* fetch_pkg.sv */
package fetch_pkg;

    // address and instruction width
    localparam int unsigned XLEN = 32;

    // one instruction is fetched as four byte reads
    localparam int unsigned BYTES_PER_INST = 4;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // byte lane within an instruction
    typedef logic [1:0] byte_idx_t;

    // branch redirect from the pipeline
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

    // request to the byte memory
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
    } mem_req_t;

    // delivered instruction, single-cycle strobe
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_out_t;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        DRAIN
    } fetch_state_e;

endpackage

/* fetch_ctrl_fsm.sv */
`timescale 1ns/1ps

module fetch_ctrl_fsm (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   redirect_valid_i,
    input  logic                   last_req_i,
    input  logic                   ret_valid_i,
    input  logic                   ret_last_i,
    output logic                   issue_en_o,
    output logic                   word_done_o,
    output fetch_pkg::fetch_state_e state_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (!stall_i) begin
                    state_d = fetch_pkg::REQUEST;
                end
            end
            fetch_pkg::REQUEST: begin
                // last byte accepted, wait for it to come back
                if (last_req_i) begin
                    state_d = fetch_pkg::DRAIN;
                end
            end
            fetch_pkg::DRAIN: begin
                if (ret_valid_i && ret_last_i) begin
                    state_d = fetch_pkg::IDLE;
                end
            end
            default: begin
                state_d = fetch_pkg::IDLE;
            end
        endcase

        // redirect wins from any state
        if (redirect_valid_i) begin
            state_d = fetch_pkg::IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= fetch_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign issue_en_o  = (state_q == fetch_pkg::REQUEST);
    // a word squashed by a redirect is never reported
    assign word_done_o = (state_q == fetch_pkg::DRAIN) && ret_valid_i && ret_last_i
                         && !redirect_valid_i;
    assign state_o     = state_q;

    // nothing accepted and nothing returning while idle
    a_no_issue_in_idle: assert property (
        @(posedge clk) disable iff (reset_i)
        (state_q == fetch_pkg::IDLE) |-> (!last_req_i && !ret_valid_i)
    );

    // the last byte only comes back while draining
    a_done_from_drain: assert property (
        @(posedge clk) disable iff (reset_i)
        (ret_valid_i && ret_last_i) |-> (state_q == fetch_pkg::DRAIN)
    );

endmodule

/* byte_counter.sv */
`timescale 1ns/1ps

module byte_counter (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 clear_i,
    input  logic                 accept_i,
    output fetch_pkg::byte_idx_t req_idx_o,
    output logic                 last_req_o,
    output logic                 ret_valid_o,
    output fetch_pkg::byte_idx_t ret_idx_o
);

    fetch_pkg::byte_idx_t req_idx_q;
    fetch_pkg::byte_idx_t ret_idx_q;
    logic                 ret_valid_q;

    // request side, wraps to zero after the fourth byte
    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            req_idx_q <= '0;
        end else if (accept_i) begin
            req_idx_q <= req_idx_q + 2'd1;
        end
    end

    // return side, one cycle behind the accepted request
    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            ret_valid_q <= 1'b0;
        end else begin
            ret_valid_q <= accept_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            ret_idx_q <= req_idx_q;
        end
    end

    assign last_req_o  = accept_i
                         && (req_idx_q == fetch_pkg::byte_idx_t'(fetch_pkg::BYTES_PER_INST - 1));
    assign req_idx_o   = req_idx_q;
    assign ret_valid_o = ret_valid_q;
    assign ret_idx_o   = ret_idx_q;

endmodule

/* pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
    input  logic                          clk,
    input  logic                          reset_i,
    input  fetch_pkg::redirect_t          redirect_i,
    input  logic                          advance_i,
    output logic [fetch_pkg::XLEN-1:0]    pc_o
);

    logic [fetch_pkg::XLEN-1:0] pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (redirect_i.valid) begin
            // redirect takes priority over a finishing word
            pc_q <= redirect_i.target;
        end else if (advance_i) begin
            pc_q <= pc_q + fetch_pkg::BYTES_PER_INST;
        end
    end

    assign pc_o = pc_q;

    // misaligned targets are not supported by the byte sequencer
    a_target_aligned: assert property (
        @(posedge clk) disable iff (reset_i)
        redirect_i.valid |-> (redirect_i.target[1:0] == 2'b00)
    );

endmodule

/* inst_assembler.sv */
`timescale 1ns/1ps

module inst_assembler (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       clear_i,
    input  logic                       ret_valid_i,
    input  fetch_pkg::byte_idx_t       ret_idx_i,
    input  logic [7:0]                 mem_byte_i,
    input  logic                       word_done_i,
    input  logic [fetch_pkg::XLEN-1:0] pc_i,
    output fetch_pkg::fetch_out_t      inst_o
);

    logic [fetch_pkg::XLEN-1:0] word_q;
    logic [fetch_pkg::XLEN-1:0] word_d;
    logic                       valid_q;
    logic [fetch_pkg::XLEN-1:0] out_pc_q;
    logic [fetch_pkg::XLEN-1:0] out_inst_q;

    // little-endian lane write, byte 0 lands in bits 7:0
    always_comb begin
        word_d = word_q;
        if (ret_valid_i) begin
            word_d[ret_idx_i*8 +: 8] = mem_byte_i;
        end
    end

    always_ff @(posedge clk) begin
        if (clear_i) begin
            word_q <= '0;
        end else begin
            word_q <= word_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= word_done_i;
        end
    end

    // last byte is merged on the fly, so the output carries word_d
    always_ff @(posedge clk) begin
        if (word_done_i) begin
            out_pc_q   <= pc_i;
            out_inst_q <= word_d;
        end
    end

    assign inst_o = '{valid: valid_q, pc: out_pc_q, inst: out_inst_q};

    // a byte in flight across a redirect must never be written
    a_no_stale_capture: assert property (
        @(posedge clk) disable iff (reset_i)
        clear_i |=> !ret_valid_i
    );

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  stall_i,
    input  fetch_pkg::redirect_t  redirect_i,
    input  logic                  mem_busy_i,
    input  logic [7:0]            mem_byte_i,
    output fetch_pkg::mem_req_t   mem_req_o,
    output fetch_pkg::fetch_out_t inst_o
);

    logic                       issue_en;
    logic                       word_done;
    logic                       accepted;
    logic                       last_req;
    logic                       ret_valid;
    logic                       ret_last;
    fetch_pkg::byte_idx_t       req_idx;
    fetch_pkg::byte_idx_t       ret_idx;
    fetch_pkg::fetch_state_e    state;
    logic [fetch_pkg::XLEN-1:0] pc;
    logic [fetch_pkg::XLEN-1:0] byte_addr;

    assign accepted  = issue_en && !mem_busy_i;
    assign ret_last  = (ret_idx == fetch_pkg::byte_idx_t'(fetch_pkg::BYTES_PER_INST - 1));
    // pc is word aligned, so the low bits just add the lane
    assign byte_addr = pc + {{(fetch_pkg::XLEN-2){1'b0}}, req_idx};
    assign mem_req_o = '{valid: issue_en, addr: byte_addr};

    fetch_ctrl_fsm i_fetch_ctrl_fsm (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_i.valid),
        .last_req_i       (last_req),
        .ret_valid_i      (ret_valid),
        .ret_last_i       (ret_last),
        .issue_en_o       (issue_en),
        .word_done_o      (word_done),
        .state_o          (state)
    );

    byte_counter i_byte_counter (
        .clk         (clk),
        .reset_i     (reset_i),
        .clear_i     (redirect_i.valid),
        .accept_i    (accepted),
        .req_idx_o   (req_idx),
        .last_req_o  (last_req),
        .ret_valid_o (ret_valid),
        .ret_idx_o   (ret_idx)
    );

    pc_unit i_pc_unit (
        .clk        (clk),
        .reset_i    (reset_i),
        .redirect_i (redirect_i),
        .advance_i  (word_done),
        .pc_o       (pc)
    );

    inst_assembler i_inst_assembler (
        .clk         (clk),
        .reset_i     (reset_i),
        .clear_i     (redirect_i.valid),
        .ret_valid_i (ret_valid),
        .ret_idx_i   (ret_idx),
        .mem_byte_i  (mem_byte_i),
        .word_done_i (word_done),
        .pc_i        (pc),
        .inst_o      (inst_o)
    );

    // refused byte is presented again at the same address
    a_retry_same_addr: assert property (
        @(posedge clk) disable iff (reset_i)
        (state == fetch_pkg::REQUEST && mem_busy_i && !redirect_i.valid)
            |=> mem_req_o.valid && $stable(mem_req_o.addr)
    );

endmodule

/* tb_byte_memory.sv */
`timescale 1ns/1ps

module tb_byte_memory #(
    parameter int MAX_BUSY_RUN = 3
) (
    input  logic                clk,
    input  logic                busy_en_i,
    input  fetch_pkg::mem_req_t req_i,
    output logic                busy_o,
    output logic [7:0]          byte_o
);

    localparam int DEPTH = 256;

    logic [7:0]  mem [DEPTH];
    integer      seed = 84308;
    logic [31:0] rnd;
    logic        busy_q = 1'b0;
    int          busy_run = 0;
    logic [7:0]  data_q = 8'h00;

    // contents first, then one busy draw per cycle from the same seed
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            rnd = $random(seed);
            mem[i] = rnd[7:0];
        end
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            // about one cycle in four, never longer than MAX_BUSY_RUN in a row
            if (busy_en_i && (busy_run < MAX_BUSY_RUN) && (rnd[1:0] == 2'b00)) begin
                busy_q   <= 1'b1;
                busy_run <= busy_run + 1;
            end else begin
                busy_q   <= 1'b0;
                busy_run <= 0;
            end
        end
    end

    // one cycle read latency
    always @(posedge clk) begin
        if (req_i.valid && !busy_q) begin
            data_q <= mem[req_i.addr[7:0]];
        end
    end

    assign busy_o = busy_q;
    assign byte_o = data_q;

endmodule

/* tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int SEQ_FETCHES    = 6;
    localparam int BUSY_FETCHES   = 8;
    // sequential, latency, busy, redirect (partial plus two), stall (two)
    localparam int TOTAL_FETCHES  = SEQ_FETCHES + 1 + BUSY_FETCHES + 3 + 2;
    localparam int FETCH_CYCLES   = 6;
    localparam int FETCH_LATENCY  = 5;
    localparam int STALL_HOLD     = 8;
    localparam int RESET_CYCLES   = 3;
    localparam int MAX_BUSY_RUN   = 3;
    localparam int TIMEOUT_CYCLES = (TOTAL_FETCHES * FETCH_CYCLES + STALL_HOLD + RESET_CYCLES)
                                    * (MAX_BUSY_RUN + 1) + 100;
    localparam logic [fetch_pkg::XLEN-1:0] REDIRECT_TARGET = 32'h0000_0080;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       stall;
    logic                       busy_en;
    fetch_pkg::redirect_t       redirect;
    logic                       mem_busy;
    logic [7:0]                 mem_byte;
    fetch_pkg::mem_req_t        mem_req;
    fetch_pkg::fetch_out_t      inst_out;
    logic [fetch_pkg::XLEN-1:0] next_pc;
    int                         cycle_count = 0;
    int                         checks = 0;
    int                         value_errors = 0;
    int                         other_errors = 0;

    always #20 clk = ~clk;

    fetch_top i_fetch_top (
        .clk        (clk),
        .reset_i    (reset),
        .stall_i    (stall),
        .redirect_i (redirect),
        .mem_busy_i (mem_busy),
        .mem_byte_i (mem_byte),
        .mem_req_o  (mem_req),
        .inst_o     (inst_out)
    );

    tb_byte_memory #(.MAX_BUSY_RUN(MAX_BUSY_RUN)) i_tb_byte_memory (
        .clk       (clk),
        .busy_en_i (busy_en),
        .req_i     (mem_req),
        .busy_o    (mem_busy),
        .byte_o    (mem_byte)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the fetch stage stopped making progress",
                     cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // little-endian word from the memory model
    function automatic logic [fetch_pkg::XLEN-1:0] expected_word(
        input logic [fetch_pkg::XLEN-1:0] addr
    );
        logic [fetch_pkg::XLEN-1:0] word;
        logic [7:0]                 idx;
        int                         k;
        word = '0;
        for (k = 0; k < 4; k++) begin
            idx = 8'(addr + 32'(k));
            word[k*8 +: 8] = i_tb_byte_memory.mem[idx];
        end
        return word;
    endfunction

    task automatic compare_fetch(input fetch_pkg::fetch_out_t got,
                                 input fetch_pkg::fetch_out_t want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display(
                "FAILED %0t inst_o: got valid=%0b pc=%h inst=%h, expected valid=%0b pc=%h inst=%h",
                $time, got.valid, got.pc, got.inst, want.valid, want.pc, want.inst);
        end
    endtask

    task automatic compare_req(input fetch_pkg::mem_req_t got, input fetch_pkg::mem_req_t want);
        checks++;
        if (got !== want) begin
            value_errors++;
            $display("FAILED %0t mem_req_o: got valid=%0b addr=%h, expected valid=%0b addr=%h",
                     $time, got.valid, got.addr, want.valid, want.addr);
        end
    endtask

    task automatic flag_problem(input string what);
        other_errors++;
        $display("%0t: %s", $time, what);
    endtask

    // follows one fetch from its first request to the delivered word
    task automatic fetch_and_check(input logic [fetch_pkg::XLEN-1:0] exp_pc,
                                   output int latency, output int refused);
        fetch_pkg::mem_req_t   exp_req;
        fetch_pkg::fetch_out_t exp_out;
        int                    accepted;
        logic                  started;
        logic                  retry_due;
        logic                  done;
        accepted  = 0;
        latency   = 0;
        refused   = 0;
        started   = 1'b0;
        retry_due = 1'b0;
        done      = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (started) begin
                latency++;
            end
            if (retry_due && !mem_req.valid) begin
                flag_problem($sformatf("refused byte of pc %h was not requested again", exp_pc));
            end
            retry_due = 1'b0;
            if (inst_out.valid) begin
                if (accepted != 4) begin
                    flag_problem($sformatf("instruction came after only %0d bytes of pc %h",
                                           accepted, exp_pc));
                end
                exp_out = '{valid: 1'b1, pc: exp_pc, inst: expected_word(exp_pc)};
                compare_fetch(inst_out, exp_out);
                if (latency != FETCH_LATENCY + refused) begin
                    flag_problem($sformatf("pc %h took %0d cycles with %0d refusals",
                                           exp_pc, latency, refused));
                end
                done = 1'b1;
            end else if (mem_req.valid) begin
                started = 1'b1;
                if (accepted >= 4) begin
                    flag_problem($sformatf("extra byte request after pc %h was complete", exp_pc));
                end
                exp_req = '{valid: 1'b1, addr: exp_pc + 32'(accepted)};
                compare_req(mem_req, exp_req);
                if (mem_busy) begin
                    refused++;
                    retry_due = 1'b1;
                end else begin
                    accepted++;
                end
            end
        end
    endtask

    task automatic sequential_fetches();
        int latency;
        int refused;
        repeat (SEQ_FETCHES) begin
            fetch_and_check(next_pc, latency, refused);
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic quiet_bus_latency();
        int latency;
        int refused;
        fetch_and_check(next_pc, latency, refused);
        next_pc = next_pc + 32'd4;
        if (refused != 0 || latency != FETCH_LATENCY) begin
            flag_problem($sformatf("quiet bus fetch took %0d cycles instead of %0d",
                                   latency, FETCH_LATENCY));
        end
    endtask

    task automatic busy_retries();
        int latency;
        int refused;
        int total_refused;
        total_refused = 0;
        busy_en <= 1'b1;
        repeat (BUSY_FETCHES) begin
            fetch_and_check(next_pc, latency, refused);
            total_refused += refused;
            next_pc = next_pc + 32'd4;
        end
        busy_en <= 1'b0;
        if (total_refused == 0) begin
            flag_problem("busy test never saw a refused request");
        end
    endtask

    // squash the fetch in flight after two bytes
    task automatic redirect_mid_fetch();
        int latency;
        int refused;
        int accepted;
        accepted = 0;
        while (accepted < 2) begin
            @(posedge clk);
            if (inst_out.valid) begin
                flag_problem("instruction delivered from the fetch about to be redirected");
            end
            if (mem_req.valid && !mem_busy) begin
                accepted++;
            end
        end
        redirect <= '{valid: 1'b1, target: REDIRECT_TARGET};
        @(posedge clk);
        redirect <= '{valid: 1'b0, target: '0};
        if (inst_out.valid) begin
            flag_problem("instruction delivered in the redirect cycle");
        end
        next_pc = REDIRECT_TARGET;
        repeat (2) begin
            fetch_and_check(next_pc, latency, refused);
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic stall_after_word();
        fetch_pkg::mem_req_t exp_req;
        int                  latency;
        int                  refused;
        // the fetch of next_pc is already under way and finishes regardless
        stall <= 1'b1;
        fetch_and_check(next_pc, latency, refused);
        next_pc = next_pc + 32'd4;
        repeat (STALL_HOLD) begin
            @(posedge clk);
            exp_req = '{valid: 1'b0, addr: next_pc};
            compare_req(mem_req, exp_req);
            if (inst_out.valid) begin
                flag_problem("instruction delivered while stalled");
            end
        end
        stall <= 1'b0;
        fetch_and_check(next_pc, latency, refused);
        next_pc = next_pc + 32'd4;
    endtask

    initial begin
        reset    <= 1'b1;
        stall    <= 1'b0;
        busy_en  <= 1'b0;
        redirect <= '0;
        next_pc  = fetch_pkg::RESET_PC;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        sequential_fetches();
        quiet_bus_latency();
        busy_retries();
        redirect_mid_fetch();
        stall_after_word();

        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
fetch_pkg.sv
fetch_ctrl_fsm.sv
byte_counter.sv
pc_unit.sv
inst_assembler.sv
fetch_top.sv
tb_byte_memory.sv
tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the fetch stage testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_fetch_top \
    -o sim_fetch
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
